// ==== hw/l2_mem_consts.svh ====
// l2 memory constants: sizes of the shared on-chip memory and its request path
`ifndef L2_MEM_CONSTS_SVH
`define L2_MEM_CONSTS_SVH

// word address into the RAM
`define L2_ADDR_W 13

// data word and byte lanes
`define L2_DATA_W 32
`define L2_BE_W 4

// 8192 words of 32 bits
`define L2_RAM_DEPTH 8192

// instruction fetch and data requesters
`define L2_NUM_PORTS 2

`endif

// ==== hw/l2_mem_pkg.sv ====
// l2 memory package: operation and state machine types for the shared memory path
package l2_mem_pkg;

    // request operation carried with every l2 request
    typedef enum logic {
        l2_read  = 1'b0,
        l2_write = 1'b1
    } l2_op_t;

    // arbiter holds one grant at a time
    typedef enum logic {
        arb_idle = 1'b0,
        arb_busy = 1'b1
    } arb_state_t;

    // adapter sequencing of one RAM access
    typedef enum logic [1:0] {
        mem_idle    = 2'd0,
        mem_access  = 2'd1,
        mem_respond = 2'd2
    } mem_state_t;

endpackage

// ==== hw/l2_mem_if.sv ====
// l2 memory interfaces: granted request path and one RAM port
`timescale 1ns/1ps
`include "l2_mem_consts.svh"

interface l2_mem_if;
    logic                               req;
    l2_mem_pkg::l2_op_t                 op;
    logic [`L2_ADDR_W-1:0]              addr;
    logic [`L2_BE_W-1:0]                be;
    logic [`L2_DATA_W-1:0]              wdata;
    logic [$clog2(`L2_NUM_PORTS)-1:0]   port_id;
    logic                               done;
    logic [`L2_DATA_W-1:0]              rdata;

    // arbiter presents the winning request
    modport arbiter (
        output req, op, addr, be, wdata, port_id,
        input  done, rdata
    );

    // adapter completes it, owner is tracked by the arbiter
    modport adapter (
        input  req, op, addr, be, wdata,
        output done, rdata
    );
endinterface

interface bram_port_if;
    logic                   en;
    logic [`L2_BE_W-1:0]    we_be;
    logic [`L2_ADDR_W-1:0]  addr;
    logic [`L2_DATA_W-1:0]  wdata;
    logic [`L2_DATA_W-1:0]  rdata;

    modport master (
        output en, we_be, addr, wdata,
        input  rdata
    );

    modport ram (
        input  en, we_be, addr, wdata,
        output rdata
    );
endinterface

// ==== hw/l2_arbiter.sv ====
// l2 arbiter: round-robin grant of two requesters onto the shared memory path
`timescale 1ns/1ps
`include "l2_mem_consts.svh"

module l2_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_0,
    input  l2_mem_pkg::l2_op_t      op_0,
    input  logic [`L2_ADDR_W-1:0]   addr_0,
    input  logic [`L2_BE_W-1:0]     be_0,
    input  logic [`L2_DATA_W-1:0]   wdata_0,
    input  logic                    req_1,
    input  l2_mem_pkg::l2_op_t      op_1,
    input  logic [`L2_ADDR_W-1:0]   addr_1,
    input  logic [`L2_BE_W-1:0]     be_1,
    input  logic [`L2_DATA_W-1:0]   wdata_1,
    output logic                    ack_0,
    output logic                    ack_1,
    output logic                    rd_valid_0,
    output logic                    rd_valid_1,
    output logic [`L2_DATA_W-1:0]   rdata_0,
    output logic [`L2_DATA_W-1:0]   rdata_1,
    l2_mem_if.arbiter               mem
);

    l2_mem_pkg::arb_state_t state;
    logic last_gnt;
    logic pick_1;
    logic grant;

    // port 1 wins when alone or when port 0 was served last
    assign pick_1 = req_1 && (!req_0 || (last_gnt == 1'b0));
    assign grant = (state == l2_mem_pkg::arb_idle) && (req_0 || req_1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= l2_mem_pkg::arb_idle;
            last_gnt <= 1'b1;
            mem.req <= 1'b0;
            mem.op <= l2_mem_pkg::l2_read;
            mem.port_id <= 1'b0;
        end else if (grant) begin
            state <= l2_mem_pkg::arb_busy;
            last_gnt <= pick_1;
            mem.req <= 1'b1;
            mem.op <= pick_1 ? op_1 : op_0;
            mem.port_id <= pick_1;
        end else if ((state == l2_mem_pkg::arb_busy) && mem.done) begin
            // grant released, next pick happens one edge later
            state <= l2_mem_pkg::arb_idle;
            mem.req <= 1'b0;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (grant) begin
            mem.addr <= pick_1 ? addr_1 : addr_0;
            mem.be <= pick_1 ? be_1 : be_0;
            mem.wdata <= pick_1 ? wdata_1 : wdata_0;
        end
    end

    assign ack_0 = mem.done && (mem.port_id == 1'b0);
    assign ack_1 = mem.done && (mem.port_id == 1'b1);

    // read data follows the ack by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_0 <= 1'b0;
            rd_valid_1 <= 1'b0;
        end else begin
            rd_valid_0 <= ack_0 && (mem.op == l2_mem_pkg::l2_read);
            rd_valid_1 <= ack_1 && (mem.op == l2_mem_pkg::l2_read);
        end
    end

    assign rdata_0 = rd_valid_0 ? mem.rdata : '0;
    assign rdata_1 = rd_valid_1 ? mem.rdata : '0;

endmodule

// ==== hw/l2_to_mem.sv ====
// l2 to memory adapter: runs one granted request on RAM port A and returns the read word
`timescale 1ns/1ps
`include "l2_mem_consts.svh"

module l2_to_mem (
    input  logic        clk,
    input  logic        rst_n,
    l2_mem_if.adapter   mem,
    bram_port_if.master ram
);

    l2_mem_pkg::mem_state_t state;
    logic [`L2_DATA_W-1:0] rdata_q;
    logic issue;

    // request is only taken from idle, so a held req is not issued twice
    assign issue = (state == l2_mem_pkg::mem_idle) && mem.req;

    assign ram.en = issue;
    assign ram.addr = mem.addr;
    assign ram.wdata = mem.wdata;
    // reads keep every lane closed
    assign ram.we_be = (mem.op == l2_mem_pkg::l2_write) ? mem.be : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= l2_mem_pkg::mem_idle;
        end else begin
            case (state)
                l2_mem_pkg::mem_idle: begin
                    if (issue) begin
                        state <= l2_mem_pkg::mem_access;
                    end
                end
                l2_mem_pkg::mem_access: begin
                    state <= l2_mem_pkg::mem_respond;
                end
                l2_mem_pkg::mem_respond: begin
                    // arbiter drops req while we sit here
                    state <= l2_mem_pkg::mem_idle;
                end
                default: begin
                    state <= l2_mem_pkg::mem_idle;
                end
            endcase
        end
    end

    // registered RAM output is valid during access
    always_ff @(posedge clk) begin
        if (state == l2_mem_pkg::mem_access) begin
            rdata_q <= ram.rdata;
        end
    end

    assign mem.done = (state == l2_mem_pkg::mem_access);
    assign mem.rdata = rdata_q;

endmodule

// ==== hw/byte_en_bram.sv ====
// byte enabled RAM: true dual port memory with lane writes and registered reads
`timescale 1ns/1ps
`include "l2_mem_consts.svh"

module byte_en_bram (
    input  logic        clk,
    bram_port_if.ram    a,
    bram_port_if.ram    b
);

    logic [`L2_DATA_W-1:0] ram [`L2_RAM_DEPTH];

    // contents start cleared
    initial begin
        for (int i = 0; i < `L2_RAM_DEPTH; i++) begin
            ram[i] = '0;
        end
    end

    // both ports in one process, read before write on each port
    always_ff @(posedge clk) begin
        if (a.en) begin
            a.rdata <= ram[a.addr];
            for (int i = 0; i < `L2_BE_W; i++) begin
                if (a.we_be[i]) begin
                    ram[a.addr][i*8 +: 8] <= a.wdata[i*8 +: 8];
                end
            end
        end
        if (b.en) begin
            b.rdata <= ram[b.addr];
            // same word from both ports is left undefined
            for (int i = 0; i < `L2_BE_W; i++) begin
                if (b.we_be[i]) begin
                    ram[b.addr][i*8 +: 8] <= b.wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hw/l2_mem_top.sv ====
// l2 memory top: two requesters share one RAM through arbiter and adapter, port B direct
`timescale 1ns/1ps
`include "l2_mem_consts.svh"

module l2_mem_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // instruction fetch requester
    input  logic                    req_0,
    input  l2_mem_pkg::l2_op_t      op_0,
    input  logic [`L2_ADDR_W-1:0]   addr_0,
    input  logic [`L2_BE_W-1:0]     be_0,
    input  logic [`L2_DATA_W-1:0]   wdata_0,
    output logic                    ack_0,
    output logic                    rd_valid_0,
    output logic [`L2_DATA_W-1:0]   rdata_0,
    // data requester
    input  logic                    req_1,
    input  l2_mem_pkg::l2_op_t      op_1,
    input  logic [`L2_ADDR_W-1:0]   addr_1,
    input  logic [`L2_BE_W-1:0]     be_1,
    input  logic [`L2_DATA_W-1:0]   wdata_1,
    output logic                    ack_1,
    output logic                    rd_valid_1,
    output logic [`L2_DATA_W-1:0]   rdata_1,
    // local master on RAM port B
    input  logic                    b_en,
    input  logic [`L2_BE_W-1:0]     b_be,
    input  logic [`L2_ADDR_W-1:0]   b_addr,
    input  logic [`L2_DATA_W-1:0]   b_wdata,
    output logic [`L2_DATA_W-1:0]   b_rdata
);

    l2_mem_if mem_bus();
    bram_port_if port_a();
    bram_port_if port_b();

    l2_arbiter l2_arb (.*, .mem(mem_bus.arbiter));

    l2_to_mem mem_adapter (.clk(clk), .rst_n(rst_n), .mem(mem_bus.adapter), .ram(port_a.master));

    byte_en_bram data_ram (.clk(clk), .a(port_a.ram), .b(port_b.ram));

    assign port_b.en = b_en;
    assign port_b.we_be = b_be;
    assign port_b.addr = b_addr;
    assign port_b.wdata = b_wdata;
    assign b_rdata = port_b.rdata;

endmodule

// ==== verif/l2_mem_clkgen.sv ====
// testbench clock and reset generator for the l2 memory path
`timescale 1ns/1ps

module l2_mem_clkgen (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // reset held for 8 cycles, released away from the edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

// ==== verif/l2_mem_assert.sv ====
// arbiter checks for exclusive single cycle acks and read data after a read ack
`timescale 1ns/1ps

module l2_mem_assert (
    input logic                 clk,
    input logic                 rst_n,
    input l2_mem_pkg::l2_op_t   op_0,
    input l2_mem_pkg::l2_op_t   op_1,
    input logic                 ack_0,
    input logic                 ack_1,
    input logic                 rd_valid_0,
    input logic                 rd_valid_1
);

    ack_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(ack_0 && ack_1))
        else $error("both requesters acked in one cycle");

    ack_0_pulse: assert property (@(posedge clk) disable iff (!rst_n) ack_0 |=> !ack_0)
        else $error("ack_0 held longer than one cycle");

    ack_1_pulse: assert property (@(posedge clk) disable iff (!rst_n) ack_1 |=> !ack_1)
        else $error("ack_1 held longer than one cycle");

    // read data comes one cycle behind the ack of a read and never behind a write
    rd_valid_0_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_0 == $past(ack_0 && (op_0 == l2_mem_pkg::l2_read)))
        else $error("rd_valid_0 does not match a read ack_0 one cycle earlier");

    rd_valid_1_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_1 == $past(ack_1 && (op_1 == l2_mem_pkg::l2_read)))
        else $error("rd_valid_1 does not match a read ack_1 one cycle earlier");

endmodule

bind l2_arbiter l2_mem_assert arb_checks (
    .clk(clk), .rst_n(rst_n), .op_0(op_0), .op_1(op_1), .ack_0(ack_0), .ack_1(ack_1),
    .rd_valid_0(rd_valid_0), .rd_valid_1(rd_valid_1)
);

// ==== verif/l2_mem_tb.sv ====
// l2 memory testbench that runs the stimulus file through both requesters and port B
`timescale 1ns/1ps
`include "l2_mem_consts.svh"

module l2_mem_tb;

    localparam int max_wait = 20;

    logic clk;
    logic rst_n;
    logic req_0;
    logic req_1;
    logic b_en;
    l2_mem_pkg::l2_op_t op_0;
    l2_mem_pkg::l2_op_t op_1;
    logic [`L2_ADDR_W-1:0] addr_0;
    logic [`L2_ADDR_W-1:0] addr_1;
    logic [`L2_ADDR_W-1:0] b_addr;
    logic [`L2_BE_W-1:0] be_0;
    logic [`L2_BE_W-1:0] be_1;
    logic [`L2_BE_W-1:0] b_be;
    logic [`L2_DATA_W-1:0] wdata_0;
    logic [`L2_DATA_W-1:0] wdata_1;
    logic [`L2_DATA_W-1:0] b_wdata;
    logic [`L2_DATA_W-1:0] rdata_0;
    logic [`L2_DATA_W-1:0] rdata_1;
    logic [`L2_DATA_W-1:0] b_rdata;
    logic ack_0;
    logic ack_1;
    logic rd_valid_0;
    logic rd_valid_1;
    logic [1:0] acks;
    logic [1:0] rvs;
    logic [31:0] stim [0:255];
    int value_errs = 0;
    int timeouts = 0;

    assign acks = {ack_1, ack_0};
    assign rvs = {rd_valid_1, rd_valid_0};

    l2_mem_clkgen clkgen (.clk(clk), .rst_n(rst_n));
    l2_mem_top uut (.*);

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            value_errs++;
        end
    endtask

    task automatic drive(input bit port, input bit on, input bit wr,
                         input logic [31:0] addr, input logic [31:0] be,
                         input logic [31:0] wdata);
        l2_mem_pkg::l2_op_t op;
        op = wr ? l2_mem_pkg::l2_write : l2_mem_pkg::l2_read;
        if (port) begin
            req_1 = on;
            op_1 = op;
            addr_1 = addr[`L2_ADDR_W-1:0];
            be_1 = be[`L2_BE_W-1:0];
            wdata_1 = wdata;
        end else begin
            req_0 = on;
            op_0 = op;
            addr_0 = addr[`L2_ADDR_W-1:0];
            be_0 = be[`L2_BE_W-1:0];
            wdata_0 = wdata;
        end
    endtask

    // one request on one port held until its ack
    task automatic single(input bit port, input bit wr, input logic [31:0] addr,
                          input logic [31:0] be, input logic [31:0] wdata,
                          input logic [31:0] exp);
        int n;
        bit acked;
        n = 0;
        acked = 0;
        drive(port, 1, wr, addr, be, wdata);
        while (n < max_wait) begin
            @(posedge clk);
            #1;
            n++;
            if (acks[port]) begin
                acked = 1;
                drive(port, 0, wr, addr, be, wdata);
            end
            if (acked && (wr || rvs[port])) break;
        end
        if (!(acked && (wr || rvs[port]))) begin
            $display("timeout: requester %0d got no response", port);
            timeouts++;
            drive(port, 0, wr, addr, be, wdata);
        end else if (wr) begin
            // let the arbiter return to idle
            @(posedge clk);
            #1;
        end else begin
            check("read_latency", 3, n);
            check(port ? "rdata_1" : "rdata_0", exp, port ? rdata_1 : rdata_0);
        end
    endtask

    // both ports read the same word in one cycle
    task automatic paired(input logic [31:0] addr, input logic [31:0] first_exp,
                          input logic [31:0] exp);
        int n;
        int first;
        bit [1:0] got;
        n = 0;
        first = -1;
        got = 2'b00;
        drive(0, 1, 0, addr, 0, 0);
        drive(1, 1, 0, addr, 0, 0);
        while (n < max_wait && got != 2'b11) begin
            @(posedge clk);
            #1;
            n++;
            if (acks != 2'b00 && first < 0) first = acks[1] ? 1 : 0;
            if (acks[0]) drive(0, 0, 0, addr, 0, 0);
            if (acks[1]) drive(1, 0, 0, addr, 0, 0);
            if (rvs[0]) begin
                got[0] = 1'b1;
                check("rdata_0", exp, rdata_0);
            end
            if (rvs[1]) begin
                got[1] = 1'b1;
                check("rdata_1", exp, rdata_1);
            end
        end
        if (got != 2'b11) begin
            $display("timeout: paired read did not complete on both requesters");
            timeouts++;
            drive(0, 0, 0, addr, 0, 0);
            drive(1, 0, 0, addr, 0, 0);
        end
        check("first_ack_port", first_exp, first);
    endtask

    task automatic b_access(input bit wr, input logic [31:0] addr, input logic [31:0] be,
                            input logic [31:0] wdata, input logic [31:0] exp);
        b_en = 1'b1;
        b_addr = addr[`L2_ADDR_W-1:0];
        b_be = wr ? be[`L2_BE_W-1:0] : '0;
        b_wdata = wdata;
        @(posedge clk);
        #1;
        b_en = 1'b0;
        if (!wr) check("b_rdata", exp, b_rdata);
    endtask

    initial begin
        int i;
        int n;
        drive(0, 0, 0, 0, 0, 0);
        drive(1, 0, 0, 0, 0, 0);
        b_en = 1'b0;
        b_addr = '0;
        b_be = '0;
        b_wdata = '0;
        $readmemh("verif/l2_mem_stimulus.txt", stim);
        // outputs stay quiet through reset and the first cycle after it
        n = 0;
        while (!rst_n && n < max_wait) begin
            @(posedge clk);
            #1;
            n++;
            check("ack_rd_valid", 0, 32'({acks, rvs}));
        end
        if (!rst_n) begin
            $display("timeout: reset was never released");
            timeouts++;
        end
        @(posedge clk);
        #1;
        check("ack_rd_valid", 0, 32'({acks, rvs}));
        i = 0;
        while (stim[i] !== 32'hff && i < 250) begin
            // kind codes 0..3 use bit 1 as port and bit 0 as write
            case (stim[i])
                0, 1, 2, 3: single(stim[i][1], stim[i][0], stim[i+1], stim[i+2],
                                   stim[i+3], stim[i+4]);
                4: paired(stim[i+1], stim[i+2], stim[i+4]);
                5, 6: b_access(stim[i][0], stim[i+1], stim[i+2], stim[i+3], stim[i+4]);
                default: begin
                    $display("unknown operation kind %0h in stimulus", stim[i]);
                    timeouts++;
                end
            endcase
            i += 5;
        end
        $display("value errors: %0d, timeouts and other failures: %0d", value_errs, timeouts);
        if (value_errs == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/l2_mem_stimulus.txt ====
// kind addr be data expected (hex); kind 0/1 rd/wr port 0, 2/3 rd/wr port 1
// kind 4 paired read with be as first acked port, kind 5/6 port B write/read
0 0010 0 00000000 00000000
3 0100 f deadbeef 00000000
2 0100 0 00000000 deadbeef
3 0200 3 11223344 00000000
3 0200 c aabbccdd 00000000
2 0200 0 00000000 aabb3344
4 0100 0 00000000 deadbeef
0 0100 0 00000000 deadbeef
4 0200 1 00000000 aabb3344
5 0300 f 5a5aa5a5 00000000
0 0300 0 00000000 5a5aa5a5
3 0400 f 0badf00d 00000000
6 0400 0 00000000 0badf00d
5 0400 1 000000ee 00000000
6 0400 0 00000000 0badf0ee
ff 0 0 0 0

// ==== l2_mem_top.f ====
+incdir+hw
hw/l2_mem_pkg.sv
hw/l2_mem_if.sv
hw/l2_arbiter.sv
hw/l2_to_mem.sv
hw/byte_en_bram.sv
hw/l2_mem_top.sv
verif/l2_mem_clkgen.sv
verif/l2_mem_assert.sv
verif/l2_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f l2_mem_top.f --top-module l2_mem_tb
out=$(./obj_dir/Vl2_mem_tb)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"
